/* hdl/game_pkg.sv */
/*
 * Shared types, colors and default geometry of the dodge game.
 * Defaults describe a 1024x768 mode; the field must lie inside the active area
 * with at least DEF_HP_BAR_HEIGHT rows above it for the hit-point bar.
 */
package game_pkg;

    typedef logic [11:0] coord_t;
    typedef logic [11:0] rgb_t;
    typedef logic [3:0]  hp_t;

    typedef enum logic [1:0] {
        GAME_IDLE,
        GAME_PLAY,
        GAME_OVER
    } game_state_e;

    // play order, advances with wrap
    typedef enum logic [1:0] {
        OBS_TOP_LEFT,
        OBS_TOP_RIGHT,
        OBS_BOTTOM_RIGHT,
        OBS_BOTTOM_LEFT
    } obstacle_id_e;

    localparam rgb_t BACK_COLOR   = 12'h1_1_3;
    localparam rgb_t BORDER_COLOR = 12'hf_f_f;
    localparam rgb_t FIELD_COLOR  = 12'h0_0_0;
    localparam rgb_t HP_COLOR     = 12'hf_0_0;
    localparam rgb_t OBSTACLE_COLOR [0:3] = '{12'hf_f_0, 12'h0_f_f, 12'h0_f_0, 12'hf_0_f};

    // 1024x768 at 60 Hz
    localparam int DEF_H_ACTIVE = 1024;
    localparam int DEF_H_FRONT  = 24;
    localparam int DEF_H_SYNC   = 136;
    localparam int DEF_H_BACK   = 160;
    localparam int DEF_V_ACTIVE = 768;
    localparam int DEF_V_FRONT  = 3;
    localparam int DEF_V_SYNC   = 6;
    localparam int DEF_V_BACK   = 29;

    localparam int DEF_FIELD_LEFT   = 361;
    localparam int DEF_FIELD_RIGHT  = 661;
    localparam int DEF_FIELD_TOP    = 317;
    localparam int DEF_FIELD_BOTTOM = 617;
    localparam int DEF_BORDER       = 7;

    localparam int DEF_HP_MAX          = 8;
    localparam int DEF_OBSTACLE_FRAMES = 4;
    localparam int DEF_HP_SEGMENT      = 16;
    localparam int DEF_HP_BAR_HEIGHT   = 8;

endpackage

/* hdl/vga_timing.sv */
/*
 * Free-running VGA counters. All outputs decode the current count, so they
 * are valid in the same cycle; syncs are active low.
 */
`timescale 1ns/100ps

module vga_timing #(
    parameter int H_ACTIVE = 1024,
    parameter int H_FRONT  = 24,
    parameter int H_SYNC   = 136,
    parameter int H_BACK   = 160,
    parameter int V_ACTIVE = 768,
    parameter int V_FRONT  = 3,
    parameter int V_SYNC   = 6,
    parameter int V_BACK   = 29
) (
    input  logic               clk,
    input  logic               rst_n,
    output game_pkg::coord_t   hcount,
    output game_pkg::coord_t   vcount,
    output logic               hsync,
    output logic               vsync,
    output logic               blank,
    output logic               frame_start
);

    localparam game_pkg::coord_t H_LAST   = game_pkg::coord_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
    localparam game_pkg::coord_t V_LAST   = game_pkg::coord_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
    localparam game_pkg::coord_t H_SYNC_0 = game_pkg::coord_t'(H_ACTIVE + H_FRONT);
    localparam game_pkg::coord_t H_SYNC_1 = game_pkg::coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam game_pkg::coord_t V_SYNC_0 = game_pkg::coord_t'(V_ACTIVE + V_FRONT);
    localparam game_pkg::coord_t V_SYNC_1 = game_pkg::coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == H_LAST) begin
            hcount <= '0;
            // line done, step the row
            vcount <= (vcount == V_LAST) ? '0 : vcount + 1'b1;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    assign hsync       = !(hcount >= H_SYNC_0 && hcount < H_SYNC_1);
    assign vsync       = !(vcount >= V_SYNC_0 && vcount < V_SYNC_1);
    assign blank       = (hcount >= game_pkg::coord_t'(H_ACTIVE)) ||
                         (vcount >= game_pkg::coord_t'(V_ACTIVE));
    assign frame_start = (hcount == '0) && (vcount == '0);

endmodule

/* hdl/obstacle_sequencer.sv */
/*
 * Game FSM and obstacle pacing. The active obstacle is one quadrant of the
 * field, split at the integer midpoints; it changes every OBSTACLE_FRAMES frames.
 */
`timescale 1ns/100ps

module obstacle_sequencer #(
    parameter int FIELD_LEFT      = 361,
    parameter int FIELD_RIGHT     = 661,
    parameter int FIELD_TOP       = 317,
    parameter int FIELD_BOTTOM    = 617,
    parameter int OBSTACLE_FRAMES = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      frame_start,
    input  logic                      game_over,
    output game_pkg::game_state_e     state,
    output game_pkg::obstacle_id_e    obstacle_id,
    output game_pkg::coord_t          obs_left,
    output game_pkg::coord_t          obs_right,
    output game_pkg::coord_t          obs_top,
    output game_pkg::coord_t          obs_bottom
);

    localparam int CNT_W = $clog2(OBSTACLE_FRAMES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(OBSTACLE_FRAMES - 1);
    localparam int H_MID = (FIELD_LEFT + FIELD_RIGHT) / 2;
    localparam int V_MID = (FIELD_TOP + FIELD_BOTTOM) / 2;

    logic [CNT_W-1:0] frame_cnt;
    logic             right_half;
    logic             bottom_half;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= game_pkg::GAME_IDLE;
            obstacle_id <= game_pkg::OBS_TOP_LEFT;
            frame_cnt   <= '0;
        end else begin
            case (state)
                game_pkg::GAME_PLAY: begin
                    if (game_over) begin
                        state <= game_pkg::GAME_OVER;
                    end else if (frame_start) begin
                        if (frame_cnt == CNT_LAST) begin
                            frame_cnt   <= '0;
                            // 2-bit enum wraps on its own
                            obstacle_id <= game_pkg::obstacle_id_e'(obstacle_id + 2'd1);
                        end else begin
                            frame_cnt <= frame_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    if (start) begin
                        state       <= game_pkg::GAME_PLAY;
                        obstacle_id <= game_pkg::OBS_TOP_LEFT;
                        frame_cnt   <= '0;
                    end
                end
            endcase
        end
    end

    // quadrant bounds
    assign right_half  = (obstacle_id == game_pkg::OBS_TOP_RIGHT) ||
                         (obstacle_id == game_pkg::OBS_BOTTOM_RIGHT);
    assign bottom_half = (obstacle_id == game_pkg::OBS_BOTTOM_RIGHT) ||
                         (obstacle_id == game_pkg::OBS_BOTTOM_LEFT);

    assign obs_left   = right_half ? game_pkg::coord_t'(H_MID + 1) : game_pkg::coord_t'(FIELD_LEFT);
    assign obs_right  = right_half ? game_pkg::coord_t'(FIELD_RIGHT) : game_pkg::coord_t'(H_MID);
    assign obs_top    = bottom_half ? game_pkg::coord_t'(V_MID + 1) : game_pkg::coord_t'(FIELD_TOP);
    assign obs_bottom = bottom_half ? game_pkg::coord_t'(FIELD_BOTTOM) : game_pkg::coord_t'(V_MID);

endmodule

/* hdl/playfield_draw.sv */
/*
 * One-stage renderer. The obstacle overrides the border and is drawn only
 * in play; position and timing leave one cycle later, aligned with field_rgb.
 */
`timescale 1ns/100ps

module playfield_draw #(
    parameter int FIELD_LEFT   = 361,
    parameter int FIELD_RIGHT  = 661,
    parameter int FIELD_TOP    = 317,
    parameter int FIELD_BOTTOM = 617,
    parameter int BORDER       = 7
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  game_pkg::coord_t          hcount,
    input  game_pkg::coord_t          vcount,
    input  logic                      hsync,
    input  logic                      vsync,
    input  logic                      blank,
    input  game_pkg::game_state_e     state,
    input  game_pkg::obstacle_id_e    obstacle_id,
    input  game_pkg::coord_t          obs_left,
    input  game_pkg::coord_t          obs_right,
    input  game_pkg::coord_t          obs_top,
    input  game_pkg::coord_t          obs_bottom,
    output game_pkg::coord_t          hcount_out,
    output game_pkg::coord_t          vcount_out,
    output logic                      hsync_out,
    output logic                      vsync_out,
    output logic                      blank_out,
    output game_pkg::rgb_t            field_rgb
);

    localparam game_pkg::coord_t IN_LEFT   = game_pkg::coord_t'(FIELD_LEFT + BORDER);
    localparam game_pkg::coord_t IN_RIGHT  = game_pkg::coord_t'(FIELD_RIGHT - BORDER);
    localparam game_pkg::coord_t IN_TOP    = game_pkg::coord_t'(FIELD_TOP + BORDER);
    localparam game_pkg::coord_t IN_BOTTOM = game_pkg::coord_t'(FIELD_BOTTOM - BORDER);

    logic           in_field;
    logic           in_inner;
    logic           in_obs;
    game_pkg::rgb_t pixel;

    assign in_field = hcount >= game_pkg::coord_t'(FIELD_LEFT) &&
                      hcount <= game_pkg::coord_t'(FIELD_RIGHT) &&
                      vcount >= game_pkg::coord_t'(FIELD_TOP) &&
                      vcount <= game_pkg::coord_t'(FIELD_BOTTOM);
    assign in_inner = hcount >= IN_LEFT && hcount <= IN_RIGHT &&
                      vcount >= IN_TOP && vcount <= IN_BOTTOM;
    assign in_obs   = (state == game_pkg::GAME_PLAY) &&
                      hcount >= obs_left && hcount <= obs_right &&
                      vcount >= obs_top && vcount <= obs_bottom;

    always_comb begin
        if (!in_field)
            pixel = game_pkg::BACK_COLOR;
        else if (in_obs)
            pixel = game_pkg::OBSTACLE_COLOR[obstacle_id];
        else if (!in_inner)
            pixel = game_pkg::BORDER_COLOR;
        else
            pixel = game_pkg::FIELD_COLOR;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync_out <= 1'b1;
            vsync_out <= 1'b1;
            blank_out <= 1'b1;
        end else begin
            hsync_out <= hsync;
            vsync_out <= vsync;
            blank_out <= blank;
        end
    end

    always_ff @(posedge clk) begin
        hcount_out <= hcount;
        vcount_out <= vcount;
        field_rgb  <= pixel;
    end

endmodule

/* hdl/hp_control.sv */
/*
 * Collision test once per frame against the rectangle held before frame_start.
 * hp saturates at 0; a start outside play reloads HP_MAX (at most 15).
 */
`timescale 1ns/100ps

module hp_control #(
    parameter int HP_MAX = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      frame_start,
    input  game_pkg::game_state_e     state,
    input  game_pkg::coord_t          xpos,
    input  game_pkg::coord_t          ypos,
    input  game_pkg::coord_t          obs_left,
    input  game_pkg::coord_t          obs_right,
    input  game_pkg::coord_t          obs_top,
    input  game_pkg::coord_t          obs_bottom,
    output game_pkg::hp_t             hp,
    output logic                      game_over
);

    logic hit;

    // inclusive bounds
    assign hit = xpos >= obs_left && xpos <= obs_right &&
                 ypos >= obs_top && ypos <= obs_bottom;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hp <= game_pkg::hp_t'(HP_MAX);
        end else if (start && state != game_pkg::GAME_PLAY) begin
            hp <= game_pkg::hp_t'(HP_MAX);
        end else if (frame_start && state == game_pkg::GAME_PLAY && hit && hp != '0) begin
            hp <= hp - 1'b1;
        end
    end

    assign game_over = (hp == '0);

endmodule

/* hdl/frame_compositor.sv */
/*
 * Hit-point bar overlay in the HP_BAR_HEIGHT rows above the field, then
 * blanking and the output registers. Needs FIELD_TOP >= HP_BAR_HEIGHT.
 */
`timescale 1ns/100ps

module frame_compositor #(
    parameter int FIELD_LEFT    = 361,
    parameter int FIELD_TOP     = 317,
    parameter int HP_MAX        = 8,
    parameter int HP_SEGMENT    = 16,
    parameter int HP_BAR_HEIGHT = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  game_pkg::coord_t  hcount,
    input  game_pkg::coord_t  vcount,
    input  logic              hsync_in,
    input  logic              vsync_in,
    input  logic              blank,
    input  game_pkg::rgb_t    field_rgb,
    input  game_pkg::hp_t     hp,
    output logic              hsync,
    output logic              vsync,
    output game_pkg::rgb_t    rgb
);

    localparam game_pkg::coord_t BAR_LEFT = game_pkg::coord_t'(FIELD_LEFT);
    localparam game_pkg::coord_t BAR_TOP  = game_pkg::coord_t'(FIELD_TOP - HP_BAR_HEIGHT);
    // widest bar, at full hit points
    localparam game_pkg::coord_t BAR_MAX  = game_pkg::coord_t'(FIELD_LEFT + HP_MAX * HP_SEGMENT);

    game_pkg::coord_t bar_end;
    logic             in_window;
    logic             bar_on;

    assign bar_end   = BAR_LEFT + game_pkg::coord_t'(hp) * game_pkg::coord_t'(HP_SEGMENT);
    assign in_window = vcount >= BAR_TOP && vcount < game_pkg::coord_t'(FIELD_TOP) &&
                       hcount >= BAR_LEFT && hcount < BAR_MAX;
    assign bar_on    = in_window && hcount < bar_end;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            rgb   <= '0;
        end else begin
            hsync <= hsync_in;
            vsync <= vsync_in;
            if (blank)
                rgb <= '0;
            else
                rgb <= bar_on ? game_pkg::HP_COLOR : field_rgb;
        end
    end

endmodule

/* hdl/dodge_core.sv */
/*
 * Dodge game core: 2-cycle latency from counters to rgb and syncs.
 * xpos and ypos are sampled once per frame, at frame_start.
 */
`timescale 1ns/100ps

module dodge_core #(
    parameter int H_ACTIVE        = game_pkg::DEF_H_ACTIVE,
    parameter int H_FRONT         = game_pkg::DEF_H_FRONT,
    parameter int H_SYNC          = game_pkg::DEF_H_SYNC,
    parameter int H_BACK          = game_pkg::DEF_H_BACK,
    parameter int V_ACTIVE        = game_pkg::DEF_V_ACTIVE,
    parameter int V_FRONT         = game_pkg::DEF_V_FRONT,
    parameter int V_SYNC          = game_pkg::DEF_V_SYNC,
    parameter int V_BACK          = game_pkg::DEF_V_BACK,
    parameter int FIELD_LEFT      = game_pkg::DEF_FIELD_LEFT,
    parameter int FIELD_RIGHT     = game_pkg::DEF_FIELD_RIGHT,
    parameter int FIELD_TOP       = game_pkg::DEF_FIELD_TOP,
    parameter int FIELD_BOTTOM    = game_pkg::DEF_FIELD_BOTTOM,
    parameter int BORDER          = game_pkg::DEF_BORDER,
    parameter int HP_MAX          = game_pkg::DEF_HP_MAX,
    parameter int OBSTACLE_FRAMES = game_pkg::DEF_OBSTACLE_FRAMES,
    parameter int HP_SEGMENT      = game_pkg::DEF_HP_SEGMENT,
    parameter int HP_BAR_HEIGHT   = game_pkg::DEF_HP_BAR_HEIGHT
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  game_pkg::coord_t  xpos,
    input  game_pkg::coord_t  ypos,
    output logic              hsync,
    output logic              vsync,
    output logic              game_over,
    output logic              playing,
    output game_pkg::rgb_t    rgb,
    output game_pkg::hp_t     hp
);

    game_pkg::coord_t       hcount_t, vcount_t, hcount_p, vcount_p;
    game_pkg::coord_t       obs_left, obs_right, obs_top, obs_bottom;
    logic                   hsync_t, vsync_t, blank_t, frame_start;
    logic                   hsync_p, vsync_p, blank_p;
    game_pkg::game_state_e  state;
    game_pkg::obstacle_id_e obstacle_id;
    game_pkg::rgb_t         field_rgb;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) vga_timing_i (
        .clk(clk), .rst_n(rst_n),
        .hcount(hcount_t), .vcount(vcount_t),
        .hsync(hsync_t), .vsync(vsync_t), .blank(blank_t), .frame_start(frame_start)
    );

    obstacle_sequencer #(
        .FIELD_LEFT(FIELD_LEFT), .FIELD_RIGHT(FIELD_RIGHT),
        .FIELD_TOP(FIELD_TOP), .FIELD_BOTTOM(FIELD_BOTTOM),
        .OBSTACLE_FRAMES(OBSTACLE_FRAMES)
    ) obstacle_sequencer_i (
        .clk(clk), .rst_n(rst_n),
        .start(start), .frame_start(frame_start), .game_over(game_over),
        .state(state), .obstacle_id(obstacle_id),
        .obs_left(obs_left), .obs_right(obs_right),
        .obs_top(obs_top), .obs_bottom(obs_bottom)
    );

    playfield_draw #(
        .FIELD_LEFT(FIELD_LEFT), .FIELD_RIGHT(FIELD_RIGHT),
        .FIELD_TOP(FIELD_TOP), .FIELD_BOTTOM(FIELD_BOTTOM),
        .BORDER(BORDER)
    ) playfield_draw_i (
        .clk(clk), .rst_n(rst_n),
        .hcount(hcount_t), .vcount(vcount_t),
        .hsync(hsync_t), .vsync(vsync_t), .blank(blank_t),
        .state(state), .obstacle_id(obstacle_id),
        .obs_left(obs_left), .obs_right(obs_right),
        .obs_top(obs_top), .obs_bottom(obs_bottom),
        .hcount_out(hcount_p), .vcount_out(vcount_p),
        .hsync_out(hsync_p), .vsync_out(vsync_p), .blank_out(blank_p),
        .field_rgb(field_rgb)
    );

    hp_control #(
        .HP_MAX(HP_MAX)
    ) hp_control_i (
        .clk(clk), .rst_n(rst_n),
        .start(start), .frame_start(frame_start), .state(state),
        .xpos(xpos), .ypos(ypos),
        .obs_left(obs_left), .obs_right(obs_right),
        .obs_top(obs_top), .obs_bottom(obs_bottom),
        .hp(hp), .game_over(game_over)
    );

    frame_compositor #(
        .FIELD_LEFT(FIELD_LEFT), .FIELD_TOP(FIELD_TOP), .HP_MAX(HP_MAX),
        .HP_SEGMENT(HP_SEGMENT), .HP_BAR_HEIGHT(HP_BAR_HEIGHT)
    ) frame_compositor_i (
        .clk(clk), .rst_n(rst_n),
        .hcount(hcount_p), .vcount(vcount_p),
        .hsync_in(hsync_p), .vsync_in(vsync_p), .blank(blank_p),
        .field_rgb(field_rgb), .hp(hp),
        .hsync(hsync), .vsync(vsync), .rgb(rgb)
    );

    assign playing = (state == game_pkg::GAME_PLAY);

endmodule

/* verif/dodge_core_checker.sv */
/*
 * Assertions bound into dodge_core. game_over may overlap playing for one
 * cycle, as the FSM leaves play the cycle after hp reaches 0.
 */
`timescale 1ns/100ps

module dodge_core_checker #(
    parameter int HP_MAX = 8
) (
    input logic           clk,
    input logic           rst_n,
    input logic           start,
    input logic           hsync,
    input logic           game_over,
    input logic           playing,
    input game_pkg::rgb_t rgb,
    input game_pkg::hp_t  hp
);

    over_leaves_play: assert property (@(posedge clk) disable iff (!rst_n)
        (game_over && playing) |=> !playing)
        else $error("playing stayed high with game_over");

    hp_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        hp <= game_pkg::hp_t'(HP_MAX))
        else $error("hp above HP_MAX");

    // reload only follows a start
    hp_rise_on_start: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && hp > $past(hp)) |-> $past(start))
        else $error("hp rose without start");

    black_after_hsync: assert property (@(posedge clk) disable iff (!rst_n)
        !hsync |=> rgb == '0)
        else $error("rgb not black after hsync");

endmodule

bind dodge_core dodge_core_checker #(
    .HP_MAX(HP_MAX)
) dodge_core_checker_i (
    .clk(clk), .rst_n(rst_n), .start(start), .hsync(hsync),
    .game_over(game_over), .playing(playing), .rgb(rgb), .hp(hp)
);

/* verif/dodge_core_tb.sv */
/*
 * Testbench for dodge_core with a 32x24 mode and a small field.
 * A cycle model of the game rules predicts rgb, syncs and status at 2-cycle latency.
 */
`timescale 1ns/100ps

module dodge_core_tb;

    localparam int H_ACT = 32, H_FP = 2, H_SW = 4, H_BP = 2, H_TOT = 40;
    localparam int V_ACT = 24, V_FP = 1, V_SW = 2, V_BP = 1, V_TOT = 28;
    localparam int FRAME = H_TOT * V_TOT;
    localparam int F_L = 4, F_R = 27, F_T = 6, F_B = 21, BRD = 1;
    localparam int HPM = 3, OBS_FR = 2, SEG = 2, BAR_H = 2;
    localparam int H_MID = (F_L + F_R) / 2, V_MID = (F_T + F_B) / 2;
    localparam int ST_IDLE = int'(game_pkg::GAME_IDLE);
    localparam int ST_PLAY = int'(game_pkg::GAME_PLAY);
    localparam int ST_OVER = int'(game_pkg::GAME_OVER);
    localparam int NROWS = 6;

    logic clk, rst_n, start, hsync, vsync, game_over, playing;
    game_pkg::coord_t xpos, ypos;
    game_pkg::rgb_t   rgb;
    game_pkg::hp_t    hp;

    // stimulus table with one row per phase
    int row_start [NROWS], row_quad [NROWS], row_rnd [NROWS], row_frames [NROWS];
    int row_hp [NROWS], row_over [NROWS], row_play [NROWS], row_obs [NROWS];

    int mh, mv, m_state, m_obs, m_cnt, m_hp, p1_h, p1_v;
    logic p1_blank, p1_hs, p1_vs, e_hs, e_vs;
    game_pkg::rgb_t p1_rgb, e_rgb;
    logic [16:0] lfsr_q;
    int errors, row_errs, failed_tests, cycles, limit;

    dodge_core #(
        .H_ACTIVE(H_ACT), .H_FRONT(H_FP), .H_SYNC(H_SW), .H_BACK(H_BP),
        .V_ACTIVE(V_ACT), .V_FRONT(V_FP), .V_SYNC(V_SW), .V_BACK(V_BP),
        .FIELD_LEFT(F_L), .FIELD_RIGHT(F_R), .FIELD_TOP(F_T), .FIELD_BOTTOM(F_B),
        .BORDER(BRD), .HP_MAX(HPM), .OBSTACLE_FRAMES(OBS_FR),
        .HP_SEGMENT(SEG), .HP_BAR_HEIGHT(BAR_H)
    ) dodge_core_i (
        .clk(clk), .rst_n(rst_n), .start(start), .xpos(xpos), .ypos(ypos),
        .hsync(hsync), .vsync(vsync), .game_over(game_over), .playing(playing),
        .rgb(rgb), .hp(hp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // quadrant bounds in obstacle enum order
    function automatic int qx0(int q);
        return (q == 1 || q == 2) ? H_MID + 1 : F_L;
    endfunction
    function automatic int qx1(int q);
        return (q == 1 || q == 2) ? F_R : H_MID;
    endfunction
    function automatic int qy0(int q);
        return (q >= 2) ? V_MID + 1 : F_T;
    endfunction
    function automatic int qy1(int q);
        return (q >= 2) ? F_B : V_MID;
    endfunction
    function automatic bit in_quad(int h, int v, int q);
        return h >= qx0(q) && h <= qx1(q) && v >= qy0(q) && v <= qy1(q);
    endfunction

    function automatic game_pkg::rgb_t field_color(int h, int v, int st, int obs);
        if (!(h >= F_L && h <= F_R && v >= F_T && v <= F_B))
            return game_pkg::BACK_COLOR;
        if (st == ST_PLAY && in_quad(h, v, obs))
            return game_pkg::OBSTACLE_COLOR[obs];
        if (h < F_L + BRD || h > F_R - BRD || v < F_T + BRD || v > F_B - BRD)
            return game_pkg::BORDER_COLOR;
        return game_pkg::FIELD_COLOR;
    endfunction

    function automatic bit in_bar(int h, int v, int hpv);
        return v >= F_T - BAR_H && v < F_T && h >= F_L && h <= F_L + hpv * SEG - 1;
    endfunction

    // fibonacci lfsr with taps 17 and 14
    function automatic logic [16:0] lfsr_step(logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val = (val << 1) | int'(lfsr_q[0]);
        end
    endtask

    task automatic place_mouse(input int q, input int rnd);
        int rx;
        int ry;
        rx = (qx1(q) - qx0(q)) / 2;
        ry = (qy1(q) - qy0(q)) / 2;
        if (rnd != 0) begin
            take_bits(4, rx);
            take_bits(3, ry);
            rx = rx % (qx1(q) - qx0(q) + 1);
            ry = ry % (qy1(q) - qy0(q) + 1);
        end
        xpos = game_pkg::coord_t'(qx0(q) + rx);
        ypos = game_pkg::coord_t'(qy0(q) + ry);
    endtask

    task automatic report(input string msg);
        errors++;
        row_errs++;
        if (row_errs <= 5)
            $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic set_row(input int i, input int st, input int q, input int rnd, input int fr,
                           input int ehp, input int eover, input int eplay, input int eobs);
        row_start[i] = st;
        row_quad[i] = q;
        row_rnd[i] = rnd;
        row_frames[i] = fr;
        row_hp[i] = ehp;
        row_over[i] = eover;
        row_play[i] = eplay;
        row_obs[i] = eobs;
    endtask

    task automatic wait_frame();
        @(negedge clk);
        while (!(mh == 0 && mv == 0))
            @(negedge clk);
    endtask

    // reference model of counters, pipeline and game rules
    always @(posedge clk) begin
        if (!rst_n) begin
            mh <= 0;
            mv <= 0;
            m_state <= ST_IDLE;
            m_obs <= 0;
            m_cnt <= 0;
            m_hp <= HPM;
            p1_blank <= 1'b1;
            p1_hs <= 1'b1;
            p1_vs <= 1'b1;
            e_hs <= 1'b1;
            e_vs <= 1'b1;
            e_rgb <= '0;
        end else begin
            mh <= (mh == H_TOT - 1) ? 0 : mh + 1;
            if (mh == H_TOT - 1)
                mv <= (mv == V_TOT - 1) ? 0 : mv + 1;
            p1_h <= mh;
            p1_v <= mv;
            p1_blank <= mh >= H_ACT || mv >= V_ACT;
            p1_hs <= !(mh >= H_ACT + H_FP && mh < H_ACT + H_FP + H_SW);
            p1_vs <= !(mv >= V_ACT + V_FP && mv < V_ACT + V_FP + V_SW);
            p1_rgb <= field_color(mh, mv, m_state, m_obs);
            e_hs <= p1_hs;
            e_vs <= p1_vs;
            if (p1_blank)
                e_rgb <= '0;
            else
                e_rgb <= in_bar(p1_h, p1_v, m_hp) ? game_pkg::HP_COLOR : p1_rgb;
            if (m_state == ST_PLAY) begin
                if (m_hp == 0) begin
                    m_state <= ST_OVER;
                end else if (mh == 0 && mv == 0) begin
                    m_cnt <= (m_cnt == OBS_FR - 1) ? 0 : m_cnt + 1;
                    if (m_cnt == OBS_FR - 1)
                        m_obs <= (m_obs + 1) % 4;
                end
            end else if (start) begin
                m_state <= ST_PLAY;
                m_obs <= 0;
                m_cnt <= 0;
            end
            if (start && m_state != ST_PLAY)
                m_hp <= HPM;
            else if (mh == 0 && mv == 0 && m_state == ST_PLAY && m_hp > 0 &&
                     in_quad(int'(xpos), int'(ypos), m_obs))
                m_hp <= m_hp - 1;
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (rgb !== e_rgb)
                report($sformatf("rgb %h, expected %h at h=%0d v=%0d", rgb, e_rgb, p1_h, p1_v));
            if (hsync !== e_hs || vsync !== e_vs)
                report($sformatf("syncs %b%b, expected %b%b", hsync, vsync, e_hs, e_vs));
            if (int'(hp) != m_hp)
                report($sformatf("hp %0d, expected %0d", hp, m_hp));
            if (game_over !== (m_hp == 0) || playing !== (m_state == ST_PLAY))
                report($sformatf("game_over/playing %b%b mismatch", game_over, playing));
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        int total;
        rst_n = 1'b0;
        start = 1'b0;
        xpos = '0;
        ypos = '0;
        lfsr_q = 17'd74471;
        errors = 0;
        failed_tests = 0;
        limit = 0;
        // start quad rnd frames | hp over play obstacle
        set_row(0, 0, 2, 1, 1, 3, 0, 0, 0);
        set_row(1, 1, 3, 1, 7, 3, 0, 1, 3);
        set_row(2, 0, 1, 1, 2, 3, 0, 1, 0);
        set_row(3, 0, 0, 0, 2, 1, 0, 1, 1);
        set_row(4, 0, 1, 0, 2, 0, 1, 0, 1);
        set_row(5, 1, 2, 1, 2, 3, 0, 1, 0);
        total = 0;
        for (int i = 0; i < NROWS; i++)
            total += row_frames[i];
        limit = (total + 3) * FRAME;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        row_errs = 0;
        @(negedge clk);
        if (playing !== 1'b0 || int'(hp) != HPM || game_over !== 1'b0)
            report("status after reset wrong");
        $display("test 0: reset status, errors=%0d", row_errs);
        if (row_errs != 0)
            failed_tests++;
        while (!(mh == 0 && mv == 0))
            @(negedge clk);
        for (int i = 0; i < NROWS; i++) begin
            row_errs = 0;
            start = row_start[i] != 0;
            place_mouse(row_quad[i], row_rnd[i]);
            @(negedge clk);
            start = 1'b0;
            for (int f = 1; f <= row_frames[i]; f++) begin
                wait_frame();
                if (f < row_frames[i])
                    place_mouse(row_quad[i], row_rnd[i]);
            end
            if (int'(hp) != row_hp[i] || int'(game_over) != row_over[i] ||
                int'(playing) != row_play[i])
                report($sformatf("row end hp=%0d over=%b playing=%b", hp, game_over, playing));
            if (int'(dodge_core_i.obstacle_id) != row_obs[i])
                report($sformatf("obstacle %0d, expected %0d",
                                 int'(dodge_core_i.obstacle_id), row_obs[i]));
            if (row_errs != 0)
                failed_tests++;
            $display("test %0d: %0d frames, errors=%0d", i + 1, row_frames[i], row_errs);
        end
        $display("tests=%0d failed=%0d errors=%0d", NROWS + 1, failed_tests, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* files.f */
hdl/game_pkg.sv
hdl/vga_timing.sv
hdl/obstacle_sequencer.sv
hdl/playfield_draw.sv
hdl/hp_control.sv
hdl/frame_compositor.sv
hdl/dodge_core.sv
verif/dodge_core_checker.sv
verif/dodge_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the dodge_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f files.f \
    --top-module dodge_core_tb \
    -o sim_dodge_core
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

out=$(./obj_dir/sim_dodge_core 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
